// ==== common/cpu_pkg.sv ====
// cpu shared definitions
package cpu_pkg;

  localparam int word_w = 16;
  localparam int reg_addr_w = 4;

  // instruction field positions
  localparam int op_hi = 15;
  localparam int op_lo = 12;
  localparam int rd_hi = 11;
  localparam int rd_lo = 8;
  localparam int ra_hi = 7;
  localparam int ra_lo = 4;
  localparam int rb_hi = 3;
  localparam int rb_lo = 0;
  localparam int imm4_hi = 3;
  localparam int imm4_lo = 0;
  localparam int imm8_hi = 7;
  localparam int imm8_lo = 0;

  typedef enum logic [3:0] {
    op_add  = 4'b0000,
    op_grt  = 4'b0001,
    op_sub  = 4'b0010,
    op_eq   = 4'b0011,
    op_jalr = 4'b0100,
    op_lui  = 4'b0101,
    op_jal  = 4'b0110,
    op_addi = 4'b1000,
    op_lw   = 4'b1001,
    op_sw   = 4'b1010,
    op_bne  = 4'b1011,
    op_wri  = 4'b1100,
    op_rea  = 4'b1101,
    op_nop  = 4'b1110,
    op_lli  = 4'b1111
  } opcode_e;

  typedef enum logic [1:0] {
    alu_add = 2'b00,
    alu_sub = 2'b01,
    alu_lui = 2'b10,
    alu_lli = 2'b11
  } alu_op_e;

  typedef enum logic [1:0] {
    src_arith = 2'b00,
    src_grt   = 2'b01,
    src_eq    = 2'b10
  } alu_src_e;

  typedef enum logic [1:0] {
    imm_s4 = 2'b00, // sign-extended bits 3..0
    imm_s8 = 2'b01,
    imm_z8 = 2'b10
  } imm_op_e;

  // alu operand selects
  localparam logic in1_ra = 1'b0;
  localparam logic in1_pc = 1'b1;
  localparam logic [1:0] in2_rb = 2'b00;
  localparam logic [1:0] in2_one = 2'b01; // link value
  localparam logic [1:0] in2_imm = 2'b10;

endpackage

// ==== logic/imm_gen.sv ====
// immediate generator
`timescale 1ns/1ps

module imm_gen (
  input  cpu_pkg::imm_op_e          imm_op,
  input  logic [cpu_pkg::word_w-1:0] instr,
  output logic [cpu_pkg::word_w-1:0] imm
);

  localparam int s4_fill = cpu_pkg::word_w - 4;
  localparam int s8_fill = cpu_pkg::word_w - 8;

  logic [3:0] imm4;
  logic [7:0] imm8;

  assign imm4 = instr[cpu_pkg::imm4_hi:cpu_pkg::imm4_lo];
  assign imm8 = instr[cpu_pkg::imm8_hi:cpu_pkg::imm8_lo];

  always_comb begin
    case (imm_op)
      cpu_pkg::imm_s4: imm = {{s4_fill{imm4[3]}}, imm4};
      cpu_pkg::imm_s8: imm = {{s8_fill{imm8[7]}}, imm8}; // jal offset
      cpu_pkg::imm_z8: imm = {{s8_fill{1'b0}}, imm8};
      default:         imm = '0;
    endcase
  end

endmodule

// ==== logic/alu.sv ====
// alu with result select
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::alu_op_e          alu_op,
  input  cpu_pkg::alu_src_e         alu_src,
  input  logic                      alu_in1,
  input  logic [1:0]                alu_in2,
  input  logic [cpu_pkg::word_w-1:0] ra_val,
  input  logic [cpu_pkg::word_w-1:0] rb_val,
  input  logic [cpu_pkg::word_w-1:0] pc,
  input  logic [cpu_pkg::word_w-1:0] imm,
  output logic [cpu_pkg::word_w-1:0] result
);

  localparam int w = cpu_pkg::word_w;
  localparam int half_w = w / 2;

  logic [w-1:0] op_a;
  logic [w-1:0] op_b;
  logic [w-1:0] arith;
  logic [w:0]   diff; // top bit is the borrow
  logic         grt;
  logic         eq;

  assign op_a = (alu_in1 == cpu_pkg::in1_pc) ? pc : ra_val;

  always_comb begin
    case (alu_in2)
      cpu_pkg::in2_one: op_b = w'(1);
      cpu_pkg::in2_imm: op_b = imm;
      default:          op_b = rb_val;
    endcase
  end

  assign diff = {1'b0, op_a} - {1'b0, op_b};
  assign eq = (diff[w-1:0] == '0);
  assign grt = !diff[w] && !eq; // unsigned a > b

  always_comb begin
    case (alu_op)
      cpu_pkg::alu_sub: arith = diff[w-1:0];
      cpu_pkg::alu_lui: arith = {op_b[half_w-1:0], {half_w{1'b0}}};
      cpu_pkg::alu_lli: arith = {ra_val[w-1:half_w], op_b[half_w-1:0]}; // ra holds old rd
      default:          arith = op_a + op_b;
    endcase
  end

  always_comb begin
    case (alu_src)
      cpu_pkg::src_grt: result = w'(grt);
      cpu_pkg::src_eq:  result = w'(eq);
      default:          result = arith;
    endcase
  end

endmodule

// ==== logic/reg_file.sv ====
// register file
`timescale 1ns/1ps

module reg_file (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [cpu_pkg::word_w-1:0] instr,
  input  logic                      reg_write,
  input  logic                      mem_to_reg,
  input  logic                      io_read,
  input  logic [cpu_pkg::word_w-1:0] result,
  input  logic [cpu_pkg::word_w-1:0] mem_rdata,
  input  logic [cpu_pkg::word_w-1:0] in_data,
  output logic [cpu_pkg::word_w-1:0] ra_val,
  output logic [cpu_pkg::word_w-1:0] rb_val,
  output logic [cpu_pkg::word_w-1:0] rd_val
);

  localparam int num_regs = 2 ** cpu_pkg::reg_addr_w;

  logic [cpu_pkg::word_w-1:0]     regs [num_regs];
  logic [cpu_pkg::reg_addr_w-1:0] rd_addr;
  logic [cpu_pkg::reg_addr_w-1:0] ra_addr;
  logic [cpu_pkg::reg_addr_w-1:0] rb_addr;
  logic [cpu_pkg::word_w-1:0]     wb_data;
  logic                           is_lli;

  assign is_lli = (instr[cpu_pkg::op_hi:cpu_pkg::op_lo] == cpu_pkg::op_lli);
  assign rd_addr = instr[cpu_pkg::rd_hi:cpu_pkg::rd_lo];
  assign ra_addr = is_lli ? rd_addr : instr[cpu_pkg::ra_hi:cpu_pkg::ra_lo]; // lli merges old rd
  assign rb_addr = instr[cpu_pkg::rb_hi:cpu_pkg::rb_lo];

  assign ra_val = regs[ra_addr];
  assign rb_val = regs[rb_addr];
  assign rd_val = regs[rd_addr];

  assign wb_data = io_read ? in_data : (mem_to_reg ? mem_rdata : result);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write && (rd_addr != '0)) begin
      regs[rd_addr] <= wb_data; // r0 stays zero
    end
  end

  // write-back takes a single source
  assert property (@(posedge clk) disable iff (reset) !(io_read && mem_to_reg));

endmodule

// ==== logic/data_mem.sv ====
// data memory
`timescale 1ns/1ps

module data_mem #(
  parameter int dmem_depth = 16
) (
  input  logic                          clk,
  input  logic                          mem_write,
  input  logic [$clog2(dmem_depth)-1:0] addr,
  input  logic [cpu_pkg::word_w-1:0]     wdata,
  output logic [cpu_pkg::word_w-1:0]     rdata
);

  logic [cpu_pkg::word_w-1:0] mem [dmem_depth];

  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem[addr] <= wdata; // sw stores rd
    end
  end

  assign rdata = mem[addr]; // async read for lw

endmodule

// ==== logic/pc_unit.sv ====
// program counter unit
`timescale 1ns/1ps

module pc_unit #(
  parameter int pc_width = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  cpu_pkg::opcode_e          op,
  input  logic                      pc_write,
  input  logic [cpu_pkg::word_w-1:0] imm,
  input  logic [cpu_pkg::word_w-1:0] ra_val,
  input  logic [cpu_pkg::word_w-1:0] rd_val,
  output logic [pc_width-1:0]       pc
);

  logic [pc_width-1:0] pc_next;
  logic [pc_width-1:0] pc_rel;
  logic [pc_width-1:0] reg_tgt;
  logic                bne_taken;

  assign pc_rel = pc + imm[pc_width-1:0]; // jal and bne
  assign reg_tgt = ra_val[pc_width-1:0] + imm[pc_width-1:0];
  assign bne_taken = (rd_val != ra_val);

  always_comb begin
    pc_next = pc + pc_width'(1);
    if (pc_write) begin
      case (op)
        cpu_pkg::op_jal:  pc_next = pc_rel;
        cpu_pkg::op_jalr: pc_next = reg_tgt;
        cpu_pkg::op_bne: begin
          if (bne_taken) begin
            pc_next = pc_rel;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // decoder raises pc_write only for control transfers
  assert property (@(posedge clk) disable iff (reset)
    pc_write |-> (op inside {cpu_pkg::op_jal, cpu_pkg::op_jalr, cpu_pkg::op_bne}));

endmodule

// ==== core/control_decoder.sv ====
// instruction decoder
`timescale 1ns/1ps

module control_decoder (
  input  cpu_pkg::opcode_e  op,
  output cpu_pkg::imm_op_e  imm_op,
  output cpu_pkg::alu_op_e  alu_op,
  output logic              alu_in1,
  output logic [1:0]        alu_in2,
  output cpu_pkg::alu_src_e alu_src,
  output logic              mem_read,
  output logic              mem_write,
  output logic              mem_to_reg,
  output logic              reg_write,
  output logic              pc_write,
  output logic              io_read,
  output logic              io_write
);

  always_comb begin
    imm_op     = cpu_pkg::imm_s4;
    alu_op     = cpu_pkg::alu_add;
    alu_in1    = cpu_pkg::in1_ra;
    alu_in2    = cpu_pkg::in2_rb;
    alu_src    = cpu_pkg::src_arith;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    mem_to_reg = 1'b0;
    reg_write  = 1'b0;
    pc_write   = 1'b0;
    io_read    = 1'b0;
    io_write   = 1'b0;
    case (op)
      cpu_pkg::op_add: reg_write = 1'b1;
      cpu_pkg::op_sub: begin
        alu_op    = cpu_pkg::alu_sub;
        reg_write = 1'b1;
      end
      cpu_pkg::op_grt: begin
        alu_op    = cpu_pkg::alu_sub;
        alu_src   = cpu_pkg::src_grt; // flag from borrow
        reg_write = 1'b1;
      end
      cpu_pkg::op_eq: begin
        alu_op    = cpu_pkg::alu_sub;
        alu_src   = cpu_pkg::src_eq;
        reg_write = 1'b1;
      end
      cpu_pkg::op_jal: begin
        imm_op    = cpu_pkg::imm_s8;
        alu_in1   = cpu_pkg::in1_pc;
        alu_in2   = cpu_pkg::in2_one; // link is pc + 1
        reg_write = 1'b1;
        pc_write  = 1'b1;
      end
      cpu_pkg::op_jalr: pc_write = 1'b1; // target built in pc_unit
      cpu_pkg::op_bne:  pc_write = 1'b1;
      cpu_pkg::op_addi: begin
        alu_in2   = cpu_pkg::in2_imm;
        reg_write = 1'b1;
      end
      cpu_pkg::op_lui, cpu_pkg::op_lli: begin
        imm_op    = cpu_pkg::imm_z8;
        alu_op    = (op == cpu_pkg::op_lui) ? cpu_pkg::alu_lui : cpu_pkg::alu_lli;
        alu_in2   = cpu_pkg::in2_imm;
        reg_write = 1'b1;
      end
      cpu_pkg::op_lw: begin
        alu_in2    = cpu_pkg::in2_imm;
        mem_read   = 1'b1;
        mem_to_reg = 1'b1;
        reg_write  = 1'b1;
      end
      cpu_pkg::op_sw: begin
        alu_in2   = cpu_pkg::in2_imm; // address = ra + s4
        mem_write = 1'b1;
      end
      cpu_pkg::op_wri: io_write = 1'b1;
      cpu_pkg::op_rea: begin
        io_read   = 1'b1;
        reg_write = 1'b1;
      end
      default: ; // nop and unused codes
    endcase

    // store and register write share no opcode
    assert (!(mem_write && reg_write));
    // load data only reaches the register file on a read
    assert (!mem_to_reg || mem_read);
  end

endmodule

// ==== core/cpu_top.sv ====
// single-cycle cpu top level
`timescale 1ns/1ps

module cpu_top #(
  parameter int pc_width = 8,
  parameter int dmem_depth = 16
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [cpu_pkg::word_w-1:0] instr,
  input  logic [cpu_pkg::word_w-1:0] in_data,
  output logic [pc_width-1:0]       pc,
  output logic [cpu_pkg::word_w-1:0] out_data,
  output logic                      out_valid
);

  localparam int dmem_aw = $clog2(dmem_depth);

  cpu_pkg::opcode_e  op;
  cpu_pkg::imm_op_e  imm_op;
  cpu_pkg::alu_op_e  alu_op;
  cpu_pkg::alu_src_e alu_src;
  logic              alu_in1;
  logic [1:0]        alu_in2;
  logic              mem_read;
  logic              mem_write;
  logic              mem_to_reg;
  logic              reg_write;
  logic              pc_write;
  logic              io_read;
  logic              io_write;

  logic [cpu_pkg::word_w-1:0] imm;
  logic [cpu_pkg::word_w-1:0] ra_val;
  logic [cpu_pkg::word_w-1:0] rb_val;
  logic [cpu_pkg::word_w-1:0] rd_val;
  logic [cpu_pkg::word_w-1:0] result;
  logic [cpu_pkg::word_w-1:0] pc_word;
  logic [cpu_pkg::word_w-1:0] dmem_rdata;
  logic [cpu_pkg::word_w-1:0] mem_rdata;

  assign op = cpu_pkg::opcode_e'(instr[cpu_pkg::op_hi:cpu_pkg::op_lo]);
  assign pc_word = cpu_pkg::word_w'(pc); // zero-extended for the alu
  assign mem_rdata = mem_read ? dmem_rdata : '0;

  control_decoder control_decoder_i (
    .op(op), .imm_op(imm_op), .alu_op(alu_op), .alu_in1(alu_in1), .alu_in2(alu_in2),
    .alu_src(alu_src), .mem_read(mem_read), .mem_write(mem_write), .mem_to_reg(mem_to_reg),
    .reg_write(reg_write), .pc_write(pc_write), .io_read(io_read), .io_write(io_write)
  );

  imm_gen imm_gen_i (.imm_op(imm_op), .instr(instr), .imm(imm));

  reg_file reg_file_i (
    .clk(clk), .reset(reset), .instr(instr), .reg_write(reg_write),
    .mem_to_reg(mem_to_reg), .io_read(io_read), .result(result), .mem_rdata(mem_rdata),
    .in_data(in_data), .ra_val(ra_val), .rb_val(rb_val), .rd_val(rd_val)
  );

  alu alu_i (
    .alu_op(alu_op), .alu_src(alu_src), .alu_in1(alu_in1), .alu_in2(alu_in2),
    .ra_val(ra_val), .rb_val(rb_val), .pc(pc_word), .imm(imm), .result(result)
  );

  data_mem #(.dmem_depth(dmem_depth)) data_mem_i (
    .clk(clk), .mem_write(mem_write), .addr(result[dmem_aw-1:0]), .wdata(rd_val),
    .rdata(dmem_rdata)
  );

  pc_unit #(.pc_width(pc_width)) pc_unit_i (
    .clk(clk), .reset(reset), .op(op), .pc_write(pc_write), .imm(imm),
    .ra_val(ra_val), .rd_val(rd_val), .pc(pc)
  );

  // output port register
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= io_write; // one-cycle strobe per wri
    end
  end

  always_ff @(posedge clk) begin
    if (io_write) begin
      out_data <= ra_val;
    end
  end

endmodule

// ==== dv/cpu_tb.sv ====
// cpu testbench
`timescale 1ns/1ps

module cpu_tb;

  localparam int pc_width = 8;
  localparam int dmem_depth = 16;
  localparam int prog_len = 46;
  localparam logic [pc_width-1:0] halt_addr = 8'd45;
  localparam int timeout_ns = (4 + prog_len * 4) * 20;
  localparam logic [15:0] nop_word = 16'hE000;

  logic                clk;
  logic                reset;
  logic [15:0]         instr;
  logic [15:0]         in_data;
  logic [pc_width-1:0] pc;
  logic [15:0]         out_data;
  logic                out_valid;

  logic [15:0]         prog [2**pc_width];
  logic [pc_width-1:0] exp_next [2**pc_width]; // next pc per address
  int                  fill_addr;
  logic [31:0]         lfsr_state;
  logic [15:0]         exp_q [$];
  logic [pc_width-1:0] exp_pc;
  logic                exp_valid;
  logic [15:0]         exp_data;

  cpu_top #(.pc_width(pc_width), .dmem_depth(dmem_depth)) cpu_top_i (
    .clk(clk), .reset(reset), .instr(instr), .in_data(in_data), .pc(pc),
    .out_data(out_data), .out_valid(out_valid)
  );

  always #10 clk = ~clk;

  function automatic logic [15:0] encode_regs(cpu_pkg::opcode_e op, int rd, int ra, int rb);
    return {op, 4'(rd), 4'(ra), 4'(rb)};
  endfunction

  function automatic logic [15:0] encode_imm8(cpu_pkg::opcode_e op, int rd, logic [7:0] imm8);
    return {op, 4'(rd), imm8};
  endfunction

  // galois lfsr
  function automatic logic next_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  function automatic logic [15:0] random_word();
    logic [15:0] w;
    for (int i = 0; i < 16; i++) begin
      w[i] = next_bit(); // one step per bit
    end
    return w;
  endfunction

  task automatic emit(logic [15:0] word);
    prog[fill_addr] = word;
    fill_addr++;
  endtask

  task automatic expect_jump(int target);
    exp_next[fill_addr - 1] = pc_width'(target); // taken transfer
  endtask

  task automatic show_reg(int ra, logic [15:0] expected);
    emit(encode_regs(cpu_pkg::op_wri, 0, ra, 0));
    exp_q.push_back(expected);
  endtask

  task automatic report_mismatch(string test, logic [15:0] expected, logic [15:0] actual);
    $display("ERROR %s expected %h actual %h", test, expected, actual);
    $display(">>> FAIL");
    $fatal(1, "check failed");
  endtask

  task automatic load_program();
    for (int i = 0; i < 2**pc_width; i++) begin
      prog[i] = nop_word;
      exp_next[i] = pc_width'(i + 1);
    end
    fill_addr = 0;
    emit(encode_imm8(cpu_pkg::op_lui, 1, 8'h12));   // r1 = 1200
    emit(encode_imm8(cpu_pkg::op_lli, 1, 8'h34));   // keeps upper 12
    show_reg(1, 16'h1234);
    emit(encode_imm8(cpu_pkg::op_lui, 2, 8'h80));   // r2 = 8000
    emit(encode_regs(cpu_pkg::op_addi, 3, 0, 5));   // r3 = 5
    emit(encode_regs(cpu_pkg::op_add, 4, 1, 3));
    show_reg(4, 16'h1239);
    emit(encode_regs(cpu_pkg::op_sub, 5, 3, 1));    // 5 - 1234 wraps
    show_reg(5, 16'hEDD1);
    emit(encode_regs(cpu_pkg::op_addi, 6, 3, 13));  // r6 = 5 - 3
    show_reg(6, 16'h0002);
    emit(encode_regs(cpu_pkg::op_grt, 7, 2, 1));    // top bit set, unsigned
    show_reg(7, 16'h0001);
    emit(encode_regs(cpu_pkg::op_grt, 7, 1, 2));
    show_reg(7, 16'h0000);
    emit(encode_regs(cpu_pkg::op_eq, 8, 1, 1));
    show_reg(8, 16'h0001);
    emit(encode_regs(cpu_pkg::op_eq, 8, 1, 4));
    show_reg(8, 16'h0000);
    emit(encode_regs(cpu_pkg::op_sw, 1, 3, 1));     // mem[6] = r1
    emit(encode_regs(cpu_pkg::op_sw, 4, 6, 0));     // mem[2] = r4
    emit(encode_regs(cpu_pkg::op_lw, 9, 6, 4));     // mem[6]
    show_reg(9, 16'h1234);
    emit(encode_regs(cpu_pkg::op_lw, 10, 3, 13));   // mem[2]
    show_reg(10, 16'h1239);
    emit(encode_regs(cpu_pkg::op_bne, 1, 1, 3));    // not taken
    emit(encode_regs(cpu_pkg::op_bne, 1, 3, 3));
    expect_jump(29);
    emit(encode_regs(cpu_pkg::op_addi, 11, 0, 7));
    emit(encode_regs(cpu_pkg::op_wri, 0, 11, 0));   // skipped by the branch
    emit(encode_imm8(cpu_pkg::op_jal, 12, 8'h04));  // link 30
    expect_jump(33);
    repeat (3) emit(nop_word);
    show_reg(12, 16'h001E);
    emit(encode_imm8(cpu_pkg::op_lli, 13, 8'h26));  // r13 = 38
    emit(encode_regs(cpu_pkg::op_jalr, 0, 13, 2));
    expect_jump(40);
    repeat (4) emit(nop_word);
    // input port echoes queue their words at run time
    emit(encode_regs(cpu_pkg::op_rea, 14, 0, 0));
    emit(encode_regs(cpu_pkg::op_wri, 0, 14, 0));
    emit(encode_regs(cpu_pkg::op_rea, 15, 0, 0));
    emit(encode_regs(cpu_pkg::op_wri, 0, 15, 0));
    emit(nop_word);
    emit(encode_imm8(cpu_pkg::op_jal, 0, 8'h00));   // halt loop
    expect_jump(45);
  endtask

  // program memory and input port
  always @(posedge clk) begin
    #2;
    instr = prog[pc];
    in_data = random_word();
  end

  // expected state after each commit
  always @(posedge clk) begin
    if (reset) begin
      exp_pc <= '0;
      exp_valid <= 1'b0;
    end else begin
      exp_pc <= exp_next[pc];
      exp_valid <= (instr[15:12] == cpu_pkg::op_wri);
      if (instr[15:12] == cpu_pkg::op_rea) begin
        exp_q.push_back(in_data);
      end
      if (instr[15:12] == cpu_pkg::op_wri) begin
        if (exp_q.size() == 0) begin
          $display("a wri committed at pc %0d with no output word expected", pc);
          $display(">>> FAIL");
          $fatal(1, "unexpected wri");
        end else begin
          exp_data <= exp_q.pop_front();
        end
      end
    end
  end

  pc_check: assert property (@(negedge clk) disable iff (reset) pc == exp_pc)
    else report_mismatch("pc sequence", 16'(exp_pc), 16'(pc));
  valid_check: assert property (@(negedge clk) disable iff (reset) out_valid == exp_valid)
    else report_mismatch("out_valid strobe", 16'(exp_valid), 16'(out_valid));
  data_check: assert property (@(negedge clk) disable iff (reset)
    exp_valid |-> out_data == exp_data)
    else report_mismatch("out_data word", exp_data, out_data);

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    instr = nop_word;
    in_data = '0;
    lfsr_state = 32'h0912_7e7f;
    load_program();
    repeat (4) @(posedge clk);
    #2 reset = 1'b0;
    wait (pc == halt_addr);
    repeat (2) @(negedge clk); // halt jal commits once more
    #1;
    if (exp_q.size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("program halted with %0d output words never written", exp_q.size());
      $display(">>> FAIL");
      $fatal(1, "missing output words");
    end
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired after %0d ns before the program halted", timeout_ns);
    $display(">>> FAIL");
    $fatal(1, "timeout");
  end

endmodule

// ==== src.f ====
common/cpu_pkg.sv
logic/imm_gen.sv
logic/alu.sv
logic/reg_file.sv
logic/data_mem.sv
logic/pc_unit.sv
core/control_decoder.sv
core/cpu_top.sv
dv/cpu_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := cpu_tb
FILELIST := src.f
OBJ_DIR  := obj_dir

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
